// ==== dv/spio_stimulus.txt ====
# header line: key0 mask0 key1 mask1 (hex), then one line per packet:
# test chan key(hex) keep expected_aer_word(hex), word is 0000 on dropped lines
12000000 ff000000 34000000 ff000000
2 0 12080105 1 0001
2 0 120a3477 1 0234
2 0 12ffff00 1 77ff
2 0 12000010 1 7800
3 0 13081000 0 0000
3 0 12100000 1 0800
3 1 34200000 1 9800
3 1 12200000 0 0000
3 1 34fe0000 1 f600
4 0 12090000 1 0100
4 1 34090000 1 8100
4 0 12456700 1 3d67
4 1 34456700 1 bd67
4 0 12c0de00 1 38de
4 1 35c0de00 0 0000
5 0 12111100 1 0911
5 0 12222200 1 1a22
5 0 12333300 1 2b33
5 0 12444400 1 3c44
5 0 12555500 1 4d55
5 0 12666600 1 5e66
5 0 12777700 1 6f77
5 0 12888800 1 0088
5 0 12999900 1 1199
5 1 34aaaa00 1 a2aa
5 1 34bbbb00 1 b3bb
5 1 34cccc00 1 c4cc

// ==== dv/spio_tb.sv ====
/*
  testbench for the spinnaker to aer output bridge
  reads packets and expected aer words from the stimulus file,
  drives both links, models the aer device and scores each word
*/

`timescale 1ns/10ps

module spio_tb;

  import spio_pkg::*;

  localparam int          MAX_LINES  = 64;
  localparam int          WAIT_LIMIT = 3000;           // cycles per wait loop
  localparam logic [31:0] SEED       = 32'hb231_089e;

  logic        clk;
  logic        rst;
  logic [31:0] key0, mask0, key1, mask1;
  spinn_pkt_t  pkt0_data;
  spinn_pkt_t  pkt1_data;
  logic        pkt0_vld, pkt0_rdy, pkt1_vld, pkt1_rdy;
  logic [15:0] aer_data;
  logic        aer_req;
  logic        aer_ack;

  // packet table from the stimulus file
  int          n_lines;
  int          line_phase [MAX_LINES];
  int          line_chan  [MAX_LINES];
  logic [31:0] line_key   [MAX_LINES];
  logic        line_keep  [MAX_LINES];
  logic [15:0] line_word  [MAX_LINES];

  logic [15:0] exp_q0 [$];     // expected words, link 0
  logic [15:0] exp_q1 [$];     // link 1
  logic [31:0] lcg_state [3];  // link 0, link 1, device
  int          phase;
  int          checks;
  int          errors;
  int          hs_errors;
  int          rx_count;
  int          keep_total;
  bit          stall_seen;

  spio_spinn2aer_if spio_spinn2aer_if_inst (
    .clk (clk), .rst (rst),
    .key0 (key0), .mask0 (mask0), .key1 (key1), .mask1 (mask1),
    .pkt0_data (pkt0_data), .pkt0_vld (pkt0_vld), .pkt0_rdy (pkt0_rdy),
    .pkt1_data (pkt1_data), .pkt1_vld (pkt1_vld), .pkt1_rdy (pkt1_rdy),
    .aer_data (aer_data), .aer_req (aer_req), .aer_ack (aer_ack)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;  // 20 ns period

  always @(negedge clk) begin
    if (phase == 5 && (!pkt0_rdy || !pkt1_rdy)) stall_seen = 1'b1;  // links pushed back
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  function automatic logic [31:0] rand_next(input int s);
    lcg_state[s] = lcg_state[s] * 32'd1664525 + 32'd1013904223;
    return lcg_state[s] >> 8;  // low bits cycle too fast
  endfunction

  function automatic int pick_delay();
    if (phase == 5) return 20 + int'(rand_next(2) % 16);  // slow device
    else return 1 + int'(rand_next(2) % 8);
  endfunction

  function automatic bit outputs_drained();
    return exp_q0.size() == 0 && exp_q1.size() == 0 && aer_req && aer_ack;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("checks %0d, errors %0d, aer words %0d", checks, errors, rx_count);
    $display("Regression failed");
    $finish;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("ERR %0t %s expected %0h got %0h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic check_handshake(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    if (got !== exp) hs_errors++;
    check_value(name, got, exp);
  endtask

  // bit 15 picks the channel queue
  task automatic score_word(input logic [15:0] word);
    int pending;
    rx_count++;
    pending = word[15] ? exp_q1.size() : exp_q0.size();
    checks++;
    assert (pending > 0) else begin
      $display("aer word %h arrived with no packet pending on its channel", word);
      errors++;
    end
    if (pending > 0 && word[15]) check_value("aer_data", word, exp_q1.pop_front());
    if (pending > 0 && !word[15]) check_value("aer_data", word, exp_q0.pop_front());
  endtask

  task automatic load_stimulus();
    int          fd;
    int          ph, ch, kp;
    logic [31:0] k;
    logic [15:0] w;
    string       line;
    bit          got_keys;
    fd = $fopen("dv/spio_stimulus.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open dv/spio_stimulus.txt");
    end else begin
      got_keys = 1'b0;
      while ($fgets(line, fd) > 0) begin
        if (line.len() > 0 && line[0] != "#") begin  // skip comment lines
          if (!got_keys) begin
            got_keys = ($sscanf(line, "%h %h %h %h", key0, mask0, key1, mask1) == 4);
          end else if ($sscanf(line, "%d %d %h %d %h", ph, ch, k, kp, w) == 5) begin
            line_phase[n_lines] = ph;
            line_chan[n_lines]  = ch;
            line_key[n_lines]   = k;
            line_keep[n_lines]  = (kp != 0);
            line_word[n_lines]  = w;
            if (kp != 0) keep_total++;
            n_lines++;
          end
        end
      end
      $fclose(fd);
      if (n_lines == 0) abort_run("stimulus file holds no packet lines");
    end
  endtask

  task automatic set_pkt(input int ch, input spinn_pkt_t pkt, input logic vld);
    if (ch == 0) begin
      pkt0_data = pkt;
      pkt0_vld  = vld;
    end else begin
      pkt1_data = pkt;
      pkt1_vld  = vld;
    end
  endtask

  // ----------------------------------------------------------------------
  // packet driver, one per link, lines in file order
  // ----------------------------------------------------------------------
  task automatic drive_chan(input int ch, input int ph);
    spinn_pkt_t pkt;
    int         gap;
    int         t;
    logic       rdy;
    for (int i = 0; i < n_lines; i++) begin
      if (line_phase[i] == ph && line_chan[i] == ch) begin
        gap = (ph == 5) ? 0 : int'(rand_next(ch) % 4);  // back to back under stall
        repeat (gap) begin
          @(posedge clk);
          #2;
        end
        pkt.ctrl    = 8'h00;
        pkt.key     = line_key[i];
        pkt.payload = rand_next(ch);  // ignored by the bridge
        if (line_keep[i] && ch == 0) exp_q0.push_back(line_word[i]);
        if (line_keep[i] && ch == 1) exp_q1.push_back(line_word[i]);
        set_pkt(ch, pkt, 1'b1);
        t = 0;
        do begin
          @(negedge clk);
          rdy = (ch == 0) ? pkt0_rdy : pkt1_rdy;
          t++;
        end while (!rdy && t < WAIT_LIMIT);
        if (!rdy) begin
          abort_run($sformatf("timeout waiting for pkt%0d_rdy", ch));
        end else begin
          @(posedge clk);  // transfer on this edge
          #2;
          set_pkt(ch, pkt, 1'b0);
        end
      end
    end
  endtask

  task automatic run_phase(input int ph, input string name);
    int e0;
    int rx0;
    int kept;
    int t;
    e0   = errors;
    rx0  = rx_count;
    kept = 0;
    for (int i = 0; i < n_lines; i++) begin
      if (line_phase[i] == ph && line_keep[i]) kept++;
    end
    phase = ph;
    @(posedge clk);
    #2;
    fork
      drive_chan(0, ph);
      drive_chan(1, ph);
    join
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (!outputs_drained() && t < WAIT_LIMIT);
    if (!outputs_drained()) begin
      abort_run($sformatf("timeout waiting for aer words in test %0d", ph));
    end else begin
      repeat (8) @(negedge clk);  // dropped packets drain, stray words show
      check_value("rx_count", rx_count - rx0, kept);
      if (ph == 5) begin
        checks++;
        assert (stall_seen) else begin
          $display("pkt_rdy never fell during the back-pressure test");
          errors++;
        end
      end
      $display("test %0d %s: %s", ph, name, (errors == e0) ? "ok" : "FAIL");
    end
  endtask

  // ----------------------------------------------------------------------
  // aer device model, four-phase, active-low req and ack
  // ----------------------------------------------------------------------
  initial begin : aer_device
    logic [15:0] word;
    int          t;
    aer_ack = 1'b1;
    forever begin
      @(negedge clk);
      if (!rst && !aer_req) begin  // new request
        word = aer_data;
        score_word(word);
        repeat (pick_delay()) begin
          @(negedge clk);
          check_handshake("aer_req", aer_req, 1'b0);  // no release before ack
          check_handshake("aer_data", aer_data, word);
        end
        @(posedge clk);
        #2 aer_ack = 1'b0;
        t = 0;
        @(negedge clk);
        while (!aer_req && t < WAIT_LIMIT) begin
          check_handshake("aer_data", aer_data, word);
          t++;
          @(negedge clk);
        end
        if (!aer_req) begin
          abort_run("timeout waiting for aer_req to rise");
        end else begin
          repeat (pick_delay()) begin
            @(negedge clk);
            check_handshake("aer_req", aer_req, 1'b1);  // no new request yet
          end
          @(posedge clk);
          #2 aer_ack = 1'b1;
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------
  initial begin : main
    int e0;
    rst       = 1'b1;
    key0      = '0;
    mask0     = '0;
    key1      = '0;
    mask1     = '0;
    pkt0_data = '0;
    pkt1_data = '0;
    pkt0_vld  = 1'b0;
    pkt1_vld  = 1'b0;
    phase     = 0;
    checks    = 0;
    errors    = 0;
    hs_errors = 0;
    rx_count  = 0;
    n_lines   = 0;
    keep_total = 0;
    stall_seen = 1'b0;
    for (int s = 0; s < 3; s++) begin
      lcg_state[s] = SEED + s;
    end
    load_stimulus();
    repeat (2) @(posedge clk);
    #2 rst = 1'b0;
    @(negedge clk);
    e0 = errors;
    check_value("aer_req", aer_req, 1'b1);
    check_value("aer_data", aer_data, 16'h0000);
    check_value("pkt0_rdy", pkt0_rdy, 1'b1);
    check_value("pkt1_rdy", pkt1_rdy, 1'b1);
    $display("test 1 reset state: %s", (errors == e0) ? "ok" : "FAIL");
    run_phase(2, "single-channel mapping");
    run_phase(3, "filtering");
    run_phase(4, "two channels together");
    run_phase(5, "back-pressure");
    $display("test 6 handshake protocol: %s", (hs_errors == 0) ? "ok" : "FAIL");
    check_value("rx_count", rx_count, keep_total);
    $display("checks %0d, errors %0d, aer words %0d of %0d kept packets",
             checks, errors, rx_count, keep_total);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== include/spio_macros.svh ====
/*
  spinnaker to aer bridge constants
  packet geometry, buffer depth and the key field
  used to build the aer neuron address
*/

`ifndef SPIO_MACROS_SVH
`define SPIO_MACROS_SVH

// ----------------------------------------------------------------------
// packet geometry
// ----------------------------------------------------------------------
`define SPIO_PKT_BITS 72        // ctrl + key + payload

// ----------------------------------------------------------------------
// buffering
// ----------------------------------------------------------------------
`define SPIO_FIFO_DEPTH 4       // default entries per fifo

// ----------------------------------------------------------------------
// address extraction
// ----------------------------------------------------------------------
`define SPIO_CORE_OFFSET 16'h0800  // core id minus one, shifted into place
`define SPIO_KEY_LSB 8             // low bit of the address field in the key

`endif

// ==== source/spio_event_merger.sv ====
/*
  two-way event merger
  round-robin choice between the two decoders, tags each
  event with its source channel and queues it for the mapper
*/

`timescale 1ns/10ps

`include "spio_macros.svh"

module spio_event_merger (
  input  logic                 clk,
  input  logic                 rst,
  input  spio_pkg::aer_event_t a_data,
  input  logic                 a_vld,
  output logic                 a_rdy,
  input  spio_pkg::aer_event_t b_data,
  input  logic                 b_vld,
  output logic                 b_rdy,
  output spio_pkg::aer_event_t evt_data,
  output logic                 evt_vld,
  input  logic                 evt_rdy
);

  import spio_pkg::*;

  logic       last_b;     // side b won the last transfer
  logic       sel_b;      // current grant
  logic       fifo_rdy;   // room in the output fifo
  logic       push_vld;
  aer_event_t push_data;

  // ----------------------------------------------------------------------
  // arbitration
  // ----------------------------------------------------------------------
  // b wins when alone or when a had the last turn
  assign sel_b = b_vld && (!a_vld || !last_b);

  assign a_rdy = fifo_rdy && !sel_b;  // only the granted side sees rdy
  assign b_rdy = fifo_rdy && sel_b;

  assign push_vld = sel_b ? b_vld : a_vld;

  always_comb begin
    push_data.chan = sel_b;                          // 0 = link a, 1 = link b
    push_data.addr = sel_b ? b_data.addr : a_data.addr;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      last_b <= 1'b1;  // a goes first after reset
    end else if (push_vld && fifo_rdy) begin
      last_b <= sel_b;
    end
  end

  // ----------------------------------------------------------------------
  // output queue
  // ----------------------------------------------------------------------
  spio_fifo #(
    .payload_t (aer_event_t),
    .DEPTH     (`SPIO_FIFO_DEPTH)
  ) evt_fifo_inst (
    .clk      (clk),
    .rst      (rst),
    .in_data  (push_data),
    .in_vld   (push_vld),
    .in_rdy   (fifo_rdy),
    .out_data (evt_data),
    .out_vld  (evt_vld),
    .out_rdy  (evt_rdy)
  );

  // a waiting side never loses two grants in a row
  a_rr_fair_a: assert property (@(posedge clk) disable iff (rst)
    (a_vld && a_rdy && b_vld) |=> (!b_vld || !a_rdy));

  a_rr_fair_b: assert property (@(posedge clk) disable iff (rst)
    (b_vld && b_rdy && a_vld) |=> (!a_vld || !b_rdy));

endmodule

// ==== source/spio_fifo.sv ====
/*
  generic synchronous fifo
  circular buffer with occupancy count, valid/ready on both
  sides, payload type set by parameter
*/

`timescale 1ns/10ps

`include "spio_macros.svh"

module spio_fifo #(
  parameter type payload_t = logic [15:0],
  parameter int  DEPTH     = `SPIO_FIFO_DEPTH
) (
  input  logic     clk,
  input  logic     rst,
  input  payload_t in_data,
  input  logic     in_vld,
  output logic     in_rdy,
  output payload_t out_data,
  output logic     out_vld,
  input  logic     out_rdy
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

  payload_t         mem [DEPTH];  // ring storage
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;        // entries held
  logic             wr_en;
  logic             rd_en;

  assign in_rdy   = (count != FULL_CNT);  // room left
  assign out_vld  = (count != '0);        // something to read
  assign out_data = mem[rd_ptr];
  assign wr_en    = in_vld && in_rdy;
  assign rd_en    = out_vld && out_rdy;

  // ----------------------------------------------------------------------
  // storage write
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_ptr] <= in_data;
  end

  // ----------------------------------------------------------------------
  // pointers and count
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + PTR_W'(1);  // wrap
      if (rd_en) rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + PTR_W'(1);
      case ({wr_en, rd_en})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;  // idle or push and pop together
      endcase
    end
  end

  // occupancy bound
  a_count_bound: assert property (@(posedge clk) disable iff (rst)
    count <= FULL_CNT);

  // write pointer holds while the buffer is full
  a_full_no_write: assert property (@(posedge clk) disable iff (rst)
    (count == FULL_CNT) |=> $stable(wr_ptr));

endmodule

// ==== source/spio_pkg.sv ====
/*
  spinnaker to aer bridge types
  multicast packet layout as seen on the link side and
  the address event passed between decoder, merger and mapper
*/

package spio_pkg;

  // ----------------------------------------------------------------------
  // spinnaker multicast packet
  // ----------------------------------------------------------------------
  // 72 bits in all, ctrl byte on top
  typedef struct packed {
    logic [7:0]  ctrl;     // packet type and flags, not decoded here
    logic [31:0] key;      // routing key
    logic [31:0] payload;  // carried along, ignored by the bridge
  } spinn_pkt_t;

  // ----------------------------------------------------------------------
  // address event
  // ----------------------------------------------------------------------
  // chan on top so the struct maps straight onto the aer word
  typedef struct packed {
    logic        chan;     // source link, set by the merger
    logic [14:0] addr;     // neuron address
  } aer_event_t;

endpackage

// ==== source/spio_pkt_decoder.sv ====
/*
  spinnaker packet decoder, one per link
  buffers packets, keeps those whose masked key matches the
  channel's routing key and turns the key into a 15-bit
  neuron address. non-matching packets are dropped quietly
*/

`timescale 1ns/10ps

`include "spio_macros.svh"

module spio_pkt_decoder (
  input  logic                clk,
  input  logic                rst,
  input  logic [31:0]         route_key,
  input  logic [31:0]         route_mask,
  input  spio_pkg::spinn_pkt_t pkt_data,
  input  logic                pkt_vld,
  output logic                pkt_rdy,
  output spio_pkg::aer_event_t evt_data,
  output logic                evt_vld,
  input  logic                evt_rdy
);

  import spio_pkg::*;

  // struct and macro must agree on the packet width
  if ($bits(spinn_pkt_t) != `SPIO_PKT_BITS) begin : g_bad_pkt_width
    $error("spinn_pkt_t does not match SPIO_PKT_BITS");
  end

  spinn_pkt_t  buf_data;   // head of the packet buffer
  logic        buf_vld;
  logic        buf_rdy;
  logic        key_match;
  logic        load;       // kept packet moves into the event register
  logic [15:0] key_field;
  logic [15:0] addr_full;

  // ----------------------------------------------------------------------
  // packet buffer
  // ----------------------------------------------------------------------
  spio_fifo #(
    .payload_t (spinn_pkt_t),
    .DEPTH     (`SPIO_FIFO_DEPTH)
  ) pkt_fifo_inst (
    .clk      (clk),
    .rst      (rst),
    .in_data  (pkt_data),
    .in_vld   (pkt_vld),
    .in_rdy   (pkt_rdy),
    .out_data (buf_data),
    .out_vld  (buf_vld),
    .out_rdy  (buf_rdy)
  );

  // ----------------------------------------------------------------------
  // key filter and address
  // ----------------------------------------------------------------------
  assign key_match = ((buf_data.key & route_mask) == (route_key & route_mask));
  assign key_field = buf_data.key[`SPIO_KEY_LSB +: 16];  // key bits 23..8
  assign addr_full = key_field - `SPIO_CORE_OFFSET;      // core id minus one

  // dropped packets pop at once, kept ones wait for the register
  assign load    = buf_vld && key_match && (!evt_vld || evt_rdy);
  assign buf_rdy = !key_match || !evt_vld || evt_rdy;

  // ----------------------------------------------------------------------
  // event register
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      evt_vld <= 1'b0;
    end else if (load) begin
      evt_vld <= 1'b1;
    end else if (evt_rdy) begin
      evt_vld <= 1'b0;  // taken downstream
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      evt_data.chan <= 1'b0;             // merger fills this in
      evt_data.addr <= addr_full[14:0];
    end
  end

  // held event does not change under back-pressure
  a_evt_stable: assert property (@(posedge clk) disable iff (rst)
    (evt_vld && !evt_rdy) |=> (evt_vld && $stable(evt_data)));

endmodule

// ==== source/spio_spinn2aer_if.sv ====
/*
  spinnaker to aer output bridge, top level
  two packet decoders, one round-robin merger and the aer
  mapper that drives the four-phase device interface
*/

`timescale 1ns/10ps

module spio_spinn2aer_if (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [31:0]          key0,
  input  logic [31:0]          mask0,
  input  logic [31:0]          key1,
  input  logic [31:0]          mask1,
  input  spio_pkg::spinn_pkt_t pkt0_data,
  input  logic                 pkt0_vld,
  output logic                 pkt0_rdy,
  input  spio_pkg::spinn_pkt_t pkt1_data,
  input  logic                 pkt1_vld,
  output logic                 pkt1_rdy,
  output logic [15:0]          aer_data,
  output logic                 aer_req,
  input  logic                 aer_ack
);

  import spio_pkg::*;

  aer_event_t evt0_data;  // decoder 0 to merger
  logic       evt0_vld;
  logic       evt0_rdy;
  aer_event_t evt1_data;  // decoder 1 to merger
  logic       evt1_vld;
  logic       evt1_rdy;
  aer_event_t mrg_data;   // merger to mapper
  logic       mrg_vld;
  logic       mrg_rdy;

  // ----------------------------------------------------------------------
  // per-link decoders
  // ----------------------------------------------------------------------
  spio_pkt_decoder dec0_inst (
    .clk (clk), .rst (rst),
    .route_key  (key0),      .route_mask (mask0),
    .pkt_data   (pkt0_data), .pkt_vld    (pkt0_vld), .pkt_rdy (pkt0_rdy),
    .evt_data   (evt0_data), .evt_vld    (evt0_vld), .evt_rdy (evt0_rdy)
  );

  spio_pkt_decoder dec1_inst (
    .clk (clk), .rst (rst),
    .route_key  (key1),      .route_mask (mask1),
    .pkt_data   (pkt1_data), .pkt_vld    (pkt1_vld), .pkt_rdy (pkt1_rdy),
    .evt_data   (evt1_data), .evt_vld    (evt1_vld), .evt_rdy (evt1_rdy)
  );

  // ----------------------------------------------------------------------
  // merge and send
  // ----------------------------------------------------------------------
  spio_event_merger merger_inst (
    .clk (clk), .rst (rst),
    .a_data   (evt0_data), .a_vld   (evt0_vld), .a_rdy   (evt0_rdy),  // chan 0
    .b_data   (evt1_data), .b_vld   (evt1_vld), .b_rdy   (evt1_rdy),  // chan 1
    .evt_data (mrg_data),  .evt_vld (mrg_vld),  .evt_rdy (mrg_rdy)
  );

  spio_spinn2aer_mapper mapper_inst (
    .clk (clk), .rst (rst),
    .evt_data (mrg_data), .evt_vld (mrg_vld), .evt_rdy (mrg_rdy),
    .aer_data (aer_data), .aer_req (aer_req), .aer_ack (aer_ack)
  );

endmodule

// ==== source/spio_spinn2aer_mapper.sv ====
/*
  aer output mapper
  sends each merged event to the aer device over a four-phase
  handshake with active-low req and ack. the aer word is the
  channel bit on top of the 15-bit neuron address
*/

`timescale 1ns/10ps

module spio_spinn2aer_mapper (
  input  logic                 clk,
  input  logic                 rst,
  input  spio_pkg::aer_event_t evt_data,
  input  logic                 evt_vld,
  output logic                 evt_rdy,
  output logic [15:0]          aer_data,
  output logic                 aer_req,
  input  logic                 aer_ack
);

  typedef enum logic [1:0] {
    IDLE_ST,    // waiting for an event
    ACK_LO_ST,  // req low, waiting for ack low
    ACK_HI_ST   // req back high, waiting for ack high
  } state_t;

  state_t state;
  logic   accept;  // event taken this cycle

  // ready only between handshakes
  assign evt_rdy = (state == IDLE_ST);
  assign accept  = evt_vld && evt_rdy;

  // ----------------------------------------------------------------------
  // handshake fsm
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= IDLE_ST;
    end else begin
      case (state)
        IDLE_ST: begin
          if (accept) state <= ACK_LO_ST;
        end
        ACK_LO_ST: begin
          if (!aer_ack) state <= ACK_HI_ST;  // ack is active low
        end
        ACK_HI_ST: begin
          if (aer_ack) state <= IDLE_ST;     // device released ack
        end
        default: state <= IDLE_ST;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // req and data
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      aer_req <= 1'b1;  // inactive high
    end else begin
      case (state)
        IDLE_ST: begin
          if (accept) aer_req <= 1'b0;    // phase 1
        end
        ACK_LO_ST: begin
          if (!aer_ack) aer_req <= 1'b1;  // phase 3
        end
        default: aer_req <= aer_req;
      endcase
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      aer_data <= 16'd0;
    end else if (accept) begin
      aer_data <= {evt_data.chan, evt_data.addr};  // chan bit on top
    end
  end

  // device sees a steady word for the whole low phase of req
  a_data_stable: assert property (@(posedge clk) disable iff (rst)
    !aer_req |=> (aer_req || $stable(aer_data)));

endmodule

// ==== verilog.f ====
+incdir+include
source/spio_pkg.sv
source/spio_fifo.sv
source/spio_pkt_decoder.sv
source/spio_event_merger.sv
source/spio_spinn2aer_mapper.sv
source/spio_spinn2aer_if.sv
dv/spio_tb.sv
